// File: execPkg.sv
package execPkg;

    localparam int XLEN = 32;
    localparam int ShamtWidth = 5;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [4:0] excCode_t;

    // encodings follow the mstatus.MPP field
    typedef enum logic [1:0] {
        PrivUser       = 2'd0,
        PrivSupervisor = 2'd1,
        PrivMachine    = 2'd3
    } privilege_t;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd,
        AluClear1,
        AluClear2
    } aluCommand_t;

    typedef enum logic [1:0] {Src1Zero, Src1Pc, Src1Reg, Src1Csr} aluSrc1_t;
    typedef enum logic [1:0] {Src2Zero, Src2Imm, Src2Reg, Src2Csr} aluSrc2_t;

    typedef enum logic [1:0] {UnitAlu, UnitBranch, UnitMul} execUnit_t;

    typedef enum logic [2:0] {
        BrEq,
        BrNe,
        BrLt,
        BrGe,
        BrLtu,
        BrGeu,
        BrAlways
    } branchCond_t;

    typedef enum logic [1:0] {WbResult, WbNextPc, WbCsr} writeSrc_t;

    typedef enum logic [1:0] {TrapNone, TrapEcall, TrapEbreak} trapOp_t;

    localparam excCode_t ExcIllegalInsn = 5'd2;
    localparam excCode_t ExcBreakpoint = 5'd3;
    // ecall cause is this base plus the privilege encoding
    localparam excCode_t ExcEcallBase = 5'd8;

    localparam logic [11:0] CsrAddrSatp = 12'h180;

endpackage

// File: aluUnit.sv
module aluUnit import execPkg::*; (
    input  aluCommand_t command,
    input  word_t       src1,
    input  word_t       src2,
    output word_t       result
);

    logic [ShamtWidth-1:0] shamt;

    assign shamt = src2[ShamtWidth-1:0];

    always_comb begin
        unique case (command)
            AluAdd: result = src1 + src2;
            AluSub: result = src1 - src2;
            AluSll: result = src1 << shamt;
            AluSlt: begin
                result = ($signed(src1) < $signed(src2)) ? word_t'(1) : word_t'(0);
            end
            AluSltu: begin
                result = (src1 < src2) ? word_t'(1) : word_t'(0);
            end
            AluXor: result = src1 ^ src2;
            AluSrl: result = src1 >> shamt;
            AluSra: result = word_t'($signed(src1) >>> shamt);
            AluOr: result = src1 | src2;
            AluAnd: result = src1 & src2;
            // csrrc style, clear bits of src1 set in src2
            AluClear1: result = src1 & ~src2;
            AluClear2: result = ~src1 & src2;
            default: result = '0;
        endcase
    end

endmodule

// File: branchUnit.sv
module branchUnit import execPkg::*; (
    input  logic        enable,
    input  branchCond_t condition,
    input  logic        indirect,
    input  word_t       pc,
    input  word_t       src1,
    input  word_t       src2,
    input  word_t       imm,
    output logic        taken,
    output word_t       target
);

    logic condMet;
    word_t indirectTarget;

    always_comb begin
        unique case (condition)
            BrEq: condMet = (src1 == src2);
            BrNe: condMet = (src1 != src2);
            BrLt: condMet = ($signed(src1) < $signed(src2));
            BrGe: condMet = ($signed(src1) >= $signed(src2));
            BrLtu: condMet = (src1 < src2);
            BrGeu: condMet = (src1 >= src2);
            BrAlways: condMet = 1'b1;
            default: condMet = 1'b0;
        endcase
    end

    assign taken = enable && condMet;

    // jalr clears bit 0 of the sum
    assign indirectTarget = (src1 + imm) & ~word_t'(1);
    assign target = indirect ? indirectTarget : pc + imm;

endmodule

// File: mulUnit.sv
module mulUnit import execPkg::*; #(
    parameter int MulCycles = XLEN
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  enable,
    input  word_t src1,
    input  word_t src2,
    output logic  busy,
    output logic  done,
    output word_t product
);

    // multiplier bits consumed per step
    localparam int BitsPerStep = XLEN / MulCycles;
    localparam int CountWidth = $clog2(MulCycles + 1);

    typedef enum logic [1:0] {MulIdle, MulRun, MulDone} mulState_t;

    mulState_t state;
    logic [CountWidth-1:0] count;
    word_t acc;
    word_t mcand;
    word_t mplier;
    logic lastStep;

    function automatic word_t stepAcc(word_t sum, word_t a, word_t b);
        word_t res;
        res = sum;
        for (int i = 0; i < BitsPerStep; i++) begin
            if (b[i]) begin
                res = res + (a << i);
            end
        end
        return res;
    endfunction

    assign lastStep = (count == CountWidth'(MulCycles - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= MulIdle;
            count <= '0;
        end else begin
            unique case (state)
                MulIdle: begin
                    if (enable) begin
                        count <= CountWidth'(1);
                        state <= (MulCycles == 1) ? MulDone : MulRun;
                    end
                end
                MulRun: begin
                    count <= count + 1'b1;
                    if (lastStep) begin
                        state <= MulDone;
                    end
                end
                default: begin
                    count <= '0;
                    state <= MulIdle;
                end
            endcase
        end
    end

    // first step happens on the load edge
    always_ff @(posedge clk) begin
        if (state == MulIdle && enable) begin
            acc <= stepAcc('0, src1, src2);
            mcand <= src1 << BitsPerStep;
            mplier <= src2 >> BitsPerStep;
        end else if (state == MulRun) begin
            acc <= stepAcc(acc, mcand, mplier);
            mcand <= mcand << BitsPerStep;
            mplier <= mplier >> BitsPerStep;
        end
    end

    assign busy = (state == MulRun) || (state == MulIdle && enable);
    assign done = (state == MulDone);
    assign product = acc;

    // upstream holds the operands for the whole multiply
    operandsHeld: assert property (@(posedge clk) disable iff (!rstN)
        state == MulRun |-> $stable(src1) && $stable(src2));

endmodule

// File: trapDetect.sv
module trapDetect import execPkg::*; (
    input  logic        valid,
    input  word_t       insn,
    input  privilege_t  privilege,
    input  logic        statusTvm,
    input  logic        statusTsr,
    input  logic        statusTw,
    input  logic        csrWriteEnableReq,
    input  logic [11:0] csrAddr,
    input  trapOp_t     trapOp,
    input  logic        isTrapReturn,
    input  privilege_t  trapReturnPriv,
    input  logic        isWfi,
    output logic        trapValid,
    output excCode_t    trapCode,
    output word_t       trapValue,
    output logic        trapReturn,
    output logic        csrPermError
);

    logic notMachine;
    logic sretBlocked;
    logic wfiBlocked;

    assign notMachine = (privilege != PrivMachine);

    // TVM forbids satp access below machine mode
    assign csrPermError = valid && statusTvm && notMachine &&
        csrWriteEnableReq && (csrAddr == CsrAddrSatp);

    assign sretBlocked = isTrapReturn && (trapReturnPriv == PrivSupervisor) && statusTsr;
    assign wfiBlocked = isWfi && notMachine && statusTw;

    always_comb begin
        trapValid = 1'b0;
        trapCode = '0;
        trapValue = '0;
        if (csrPermError) begin
            trapValid = 1'b1;
            trapCode = ExcIllegalInsn;
            trapValue = insn;
        end else if (valid && trapOp == TrapEcall) begin
            trapValid = 1'b1;
            trapCode = ExcEcallBase + excCode_t'(privilege);
        end else if (valid && trapOp == TrapEbreak) begin
            trapValid = 1'b1;
            trapCode = ExcBreakpoint;
        end else if (valid && sretBlocked) begin
            trapValid = 1'b1;
            trapCode = ExcIllegalInsn;
            trapValue = insn;
        end else if (valid && wfiBlocked) begin
            trapValid = 1'b1;
            trapCode = ExcIllegalInsn;
            trapValue = insn;
        end
    end

    assign trapReturn = valid && isTrapReturn && !trapValid;

    always_comb begin
        noTrapOnReturn: assert final (!(trapValid && trapReturn));
    end

endmodule

// File: executeStage.sv
module executeStage import execPkg::*; #(
    parameter int MulCycles = XLEN
) (
    input  logic        clk,
    input  logic        rstN,

    input  logic        valid,
    input  word_t       pc,
    input  word_t       insn,
    input  logic        isCompressed,
    input  execUnit_t   unit,
    input  aluCommand_t aluCommand,
    input  aluSrc1_t    aluSrc1Sel,
    input  aluSrc2_t    aluSrc2Sel,
    input  writeSrc_t   writeSrc,
    input  word_t       imm,
    input  branchCond_t brCond,
    input  logic        brIndirect,
    input  word_t       rs1Value,
    input  word_t       rs2Value,
    input  regAddr_t    rd,
    input  logic        intRegWriteEnable,
    input  logic [11:0] csrAddr,
    input  word_t       csrReadValue,
    input  logic        csrWriteEnableReq,
    input  privilege_t  privilege,
    input  logic        statusTvm,
    input  logic        statusTsr,
    input  logic        statusTw,
    input  trapOp_t     trapOp,
    input  logic        isTrapReturn,
    input  privilege_t  trapReturnPriv,
    input  logic        isWfi,
    input  logic        bypassHit1,
    input  word_t       bypassValue1,
    input  logic        bypassHit2,
    input  word_t       bypassValue2,

    output logic        exStallReq,
    output logic        flushReq,
    output word_t       flushTarget,
    output logic        csrWriteEnable,
    output word_t       csrWriteValue,
    output logic        bypassWriteEnable,
    output regAddr_t    bypassWriteAddr,
    output word_t       bypassWriteValue,

    output logic        outValid,
    output word_t       outPc,
    output word_t       outInsn,
    output word_t       outDstValue,
    output logic        outBranchTaken,
    output word_t       outBranchTarget,
    output logic        outTrapValid,
    output excCode_t    outTrapCode,
    output word_t       outTrapValue,
    output logic        outTrapReturn
);

    word_t src1;
    word_t src2;
    word_t aluSrc1;
    word_t aluSrc2;
    word_t aluResult;
    word_t intResult;
    word_t dstValue;
    word_t nextPc;

    logic enableBranch;
    logic enableMul;
    logic branchTaken;
    word_t branchTarget;

    logic mulBusy;
    logic mulDone;
    word_t mulProduct;

    logic trapValid;
    excCode_t trapCode;
    word_t trapValue;
    logic trapReturn;
    logic csrPermError;

    assign enableBranch = valid && (unit == UnitBranch);
    assign enableMul = valid && (unit == UnitMul);

    // forwarded values win over the register file read
    assign src1 = bypassHit1 ? bypassValue1 : rs1Value;
    assign src2 = bypassHit2 ? bypassValue2 : rs2Value;

    always_comb begin
        unique case (aluSrc1Sel)
            Src1Pc: aluSrc1 = pc;
            Src1Reg: aluSrc1 = src1;
            Src1Csr: aluSrc1 = csrReadValue;
            default: aluSrc1 = '0;
        endcase
        unique case (aluSrc2Sel)
            Src2Imm: aluSrc2 = imm;
            Src2Reg: aluSrc2 = src2;
            Src2Csr: aluSrc2 = csrReadValue;
            default: aluSrc2 = '0;
        endcase
    end

    aluUnit alu (
        .command(aluCommand),
        .src1(aluSrc1),
        .src2(aluSrc2),
        .result(aluResult)
    );

    branchUnit branch (
        .enable(enableBranch),
        .condition(brCond),
        .indirect(brIndirect),
        .pc(pc),
        .src1(src1),
        .src2(src2),
        .imm(imm),
        .taken(branchTaken),
        .target(branchTarget)
    );

    mulUnit #(
        .MulCycles(MulCycles)
    ) mul (
        .clk(clk),
        .rstN(rstN),
        .enable(enableMul),
        .src1(src1),
        .src2(src2),
        .busy(mulBusy),
        .done(mulDone),
        .product(mulProduct)
    );

    trapDetect trap (
        .valid(valid),
        .insn(insn),
        .privilege(privilege),
        .statusTvm(statusTvm),
        .statusTsr(statusTsr),
        .statusTw(statusTw),
        .csrWriteEnableReq(csrWriteEnableReq),
        .csrAddr(csrAddr),
        .trapOp(trapOp),
        .isTrapReturn(isTrapReturn),
        .trapReturnPriv(trapReturnPriv),
        .isWfi(isWfi),
        .trapValid(trapValid),
        .trapCode(trapCode),
        .trapValue(trapValue),
        .trapReturn(trapReturn),
        .csrPermError(csrPermError)
    );

    assign intResult = (unit == UnitMul) ? mulProduct : aluResult;
    assign nextPc = pc + (isCompressed ? word_t'(2) : word_t'(4));

    always_comb begin
        unique case (writeSrc)
            WbResult: dstValue = intResult;
            WbNextPc: dstValue = nextPc;
            WbCsr: dstValue = csrReadValue;
            default: dstValue = '0;
        endcase
    end

    assign exStallReq = mulBusy;

    assign csrWriteEnable = valid && csrWriteEnableReq && !trapValid && !csrPermError;
    assign csrWriteValue = aluResult;

    // any csr write flushes, later stages may depend on the new value
    assign flushReq = valid && !exStallReq &&
        (branchTaken || csrWriteEnableReq || trapValid || trapReturn);
    assign flushTarget = branchTaken ? branchTarget : nextPc;

    assign bypassWriteEnable = valid && intRegWriteEnable && !exStallReq;
    assign bypassWriteAddr = rd;
    assign bypassWriteValue = dstValue;

    always_ff @(posedge clk) begin
        if (!rstN || exStallReq) begin
            outValid <= 1'b0;
            outPc <= '0;
            outInsn <= '0;
            outDstValue <= '0;
            outBranchTaken <= 1'b0;
            outBranchTarget <= '0;
            outTrapValid <= 1'b0;
            outTrapCode <= '0;
            outTrapValue <= '0;
            outTrapReturn <= 1'b0;
        end else begin
            outValid <= valid;
            outPc <= pc;
            outInsn <= insn;
            outDstValue <= dstValue;
            outBranchTaken <= branchTaken;
            outBranchTarget <= branchTarget;
            outTrapValid <= trapValid;
            outTrapCode <= trapCode;
            outTrapValue <= trapValue;
            outTrapReturn <= trapReturn;
        end
    end

    flushNotStalled: assert property (@(posedge clk) disable iff (!rstN)
        flushReq |-> !exStallReq);

    // done comes right after exactly MulCycles stalled cycles
    mulStallLength: assert property (@(posedge clk) disable iff (!rstN)
        mulDone |-> $past(mulBusy, MulCycles) && !$past(mulBusy, MulCycles + 1));

endmodule

// File: executeStageTb.sv
module executeStageTb import execPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MulCycles = XLEN;
    // the tests take about 350 cycles
    localparam int TimeoutCycles = 2000;

    logic clk;
    logic rstN;
    logic valid;
    word_t pc;
    word_t insn;
    logic isCompressed;
    execUnit_t unit;
    aluCommand_t aluCommand;
    aluSrc1_t aluSrc1Sel;
    aluSrc2_t aluSrc2Sel;
    writeSrc_t writeSrc;
    word_t imm;
    branchCond_t brCond;
    logic brIndirect;
    word_t rs1Value;
    word_t rs2Value;
    regAddr_t rd;
    logic intRegWriteEnable;
    logic [11:0] csrAddr;
    word_t csrReadValue;
    logic csrWriteEnableReq;
    privilege_t privilege;
    logic statusTvm;
    logic statusTsr;
    logic statusTw;
    trapOp_t trapOp;
    logic isTrapReturn;
    privilege_t trapReturnPriv;
    logic isWfi;
    logic bypassHit1;
    word_t bypassValue1;
    logic bypassHit2;
    word_t bypassValue2;
    logic exStallReq;
    logic flushReq;
    word_t flushTarget;
    logic csrWriteEnable;
    word_t csrWriteValue;
    logic bypassWriteEnable;
    regAddr_t bypassWriteAddr;
    word_t bypassWriteValue;
    logic outValid;
    word_t outPc;
    word_t outInsn;
    word_t outDstValue;
    logic outBranchTaken;
    word_t outBranchTarget;
    logic outTrapValid;
    excCode_t outTrapCode;
    word_t outTrapValue;
    logic outTrapReturn;

    integer seed;
    int errorCount;
    int testCount;
    int cycleCount;

    executeStage dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t aluRef(aluCommand_t cmd, word_t a, word_t b);
        int sh;
        word_t signFill;
        sh = b[4:0];
        signFill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (cmd)
            AluAdd: return a + b;
            AluSub: return a + ~b + 32'd1;
            AluSll: return a << sh;
            AluSlt: return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            AluSltu: return (a < b) ? 32'd1 : 32'd0;
            AluXor: return (a | b) & ~(a & b);
            AluSrl: return a >> sh;
            AluSra: return (a >> sh) | signFill;
            AluOr: return a | b;
            AluAnd: return a & b;
            AluClear1: return a & ~b;
            AluClear2: return ~a & b;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic branchRef(branchCond_t cond, word_t a, word_t b);
        logic lessSigned;
        lessSigned = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (cond)
            BrEq: return a == b;
            BrNe: return a != b;
            BrLt: return lessSigned;
            BrGe: return !lessSigned;
            BrLtu: return a < b;
            BrGeu: return !(a < b);
            default: return 1'b1;
        endcase
    endfunction

    task automatic reportMismatch(string name, word_t expected, word_t actual);
        $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic reportTest(string name, int startErrors);
        $display("%s test finished with %0d errors", name, errorCount - startErrors);
        testCount++;
    endtask

    task automatic driveIdle();
        valid = 1'b0;
        pc = '0;
        insn = '0;
        isCompressed = 1'b0;
        unit = UnitAlu;
        aluCommand = AluAdd;
        aluSrc1Sel = Src1Zero;
        aluSrc2Sel = Src2Zero;
        writeSrc = WbResult;
        imm = '0;
        brCond = BrEq;
        brIndirect = 1'b0;
        rs1Value = '0;
        rs2Value = '0;
        rd = '0;
        intRegWriteEnable = 1'b0;
        csrAddr = '0;
        csrReadValue = '0;
        csrWriteEnableReq = 1'b0;
        privilege = PrivMachine;
        statusTvm = 1'b0;
        statusTsr = 1'b0;
        statusTw = 1'b0;
        trapOp = TrapNone;
        isTrapReturn = 1'b0;
        trapReturnPriv = PrivMachine;
        isWfi = 1'b0;
        bypassHit1 = 1'b0;
        bypassValue1 = '0;
        bypassHit2 = 1'b0;
        bypassValue2 = '0;
    endtask

    task automatic testReset();
        int startErrors;
        startErrors = errorCount;
        #5;
        if (exStallReq !== 1'b0) reportMismatch("exStallReq", 0, exStallReq);
        if (flushReq !== 1'b0) reportMismatch("flushReq", 0, flushReq);
        if (csrWriteEnable !== 1'b0) reportMismatch("csrWriteEnable", 0, csrWriteEnable);
        @(negedge clk);
        if (outValid !== 1'b0) reportMismatch("outValid", 0, outValid);
        if (outTrapValid !== 1'b0) reportMismatch("outTrapValid", 0, outTrapValid);
        reportTest("reset", startErrors);
    endtask

    task automatic testAlu();
        int startErrors;
        word_t rnd;
        word_t a;
        word_t b;
        word_t expected;
        startErrors = errorCount;
        for (int c = 0; c < 12; c++) begin
            for (int s1 = 0; s1 < 4; s1++) begin
                for (int s2 = 0; s2 < 4; s2++) begin
                    driveIdle();
                    valid = 1'b1;
                    aluCommand = aluCommand_t'(c);
                    aluSrc1Sel = aluSrc1_t'(s1);
                    aluSrc2Sel = aluSrc2_t'(s2);
                    intRegWriteEnable = 1'b1;
                    pc = $random(seed);
                    insn = $random(seed);
                    imm = $random(seed);
                    csrReadValue = $random(seed);
                    rs1Value = $random(seed);
                    rs2Value = $random(seed);
                    bypassValue1 = $random(seed);
                    bypassValue2 = $random(seed);
                    rnd = $random(seed);
                    bypassHit1 = rnd[0];
                    bypassHit2 = rnd[1];
                    rd = rnd[6:2];
                    case (s1)
                        0: a = '0;
                        1: a = pc;
                        2: a = bypassHit1 ? bypassValue1 : rs1Value;
                        default: a = csrReadValue;
                    endcase
                    case (s2)
                        0: b = '0;
                        1: b = imm;
                        2: b = bypassHit2 ? bypassValue2 : rs2Value;
                        default: b = csrReadValue;
                    endcase
                    expected = aluRef(aluCommand_t'(c), a, b);
                    #5;
                    if (bypassWriteEnable !== 1'b1) begin
                        reportMismatch("bypassWriteEnable", 1, bypassWriteEnable);
                    end
                    if (bypassWriteAddr !== rd) begin
                        reportMismatch("bypassWriteAddr", rd, bypassWriteAddr);
                    end
                    if (bypassWriteValue !== expected) begin
                        reportMismatch("bypassWriteValue", expected, bypassWriteValue);
                    end
                    @(negedge clk);
                    if (outDstValue !== expected) reportMismatch("outDstValue", expected, outDstValue);
                    if (outPc !== pc) reportMismatch("outPc", pc, outPc);
                    if (outInsn !== insn) reportMismatch("outInsn", insn, outInsn);
                end
            end
        end
        // link value for both instruction sizes
        for (int comp = 0; comp < 2; comp++) begin
            driveIdle();
            valid = 1'b1;
            writeSrc = WbNextPc;
            isCompressed = comp[0];
            pc = $random(seed);
            expected = pc + ((comp == 1) ? 32'd2 : 32'd4);
            @(negedge clk);
            if (outDstValue !== expected) reportMismatch("outDstValue", expected, outDstValue);
        end
        reportTest("alu", startErrors);
    endtask

    task automatic testBranch();
        int startErrors;
        word_t a;
        word_t b;
        word_t target;
        logic taken;
        startErrors = errorCount;
        for (int c = 0; c < 7; c++) begin
            for (int same = 0; same < 2; same++) begin
                for (int ind = 0; ind < 2; ind++) begin
                    driveIdle();
                    valid = 1'b1;
                    unit = UnitBranch;
                    writeSrc = WbNextPc;
                    brCond = branchCond_t'(c);
                    brIndirect = ind[0];
                    pc = $random(seed) & 32'hffff_fffc;
                    imm = $random(seed);
                    a = $random(seed);
                    b = (same == 1) ? a : $random(seed);
                    if (same == 0 && b == a) b = a + 32'd1;
                    rs1Value = a;
                    rs2Value = b;
                    taken = branchRef(branchCond_t'(c), a, b);
                    target = (ind == 1) ? ((a + imm) & 32'hffff_fffe) : pc + imm;
                    #5;
                    if (flushReq !== taken) reportMismatch("flushReq", taken, flushReq);
                    if (taken && flushTarget !== target) begin
                        reportMismatch("flushTarget", target, flushTarget);
                    end
                    if (!taken && flushTarget !== pc + 32'd4) begin
                        reportMismatch("flushTarget", pc + 32'd4, flushTarget);
                    end
                    @(negedge clk);
                    if (outBranchTaken !== taken) reportMismatch("outBranchTaken", taken, outBranchTaken);
                    if (outBranchTarget !== target) begin
                        reportMismatch("outBranchTarget", target, outBranchTarget);
                    end
                end
            end
        end
        reportTest("branch", startErrors);
    endtask

    task automatic testMultiply();
        int startErrors;
        int stallCycles;
        word_t product;
        startErrors = errorCount;
        // the second multiply follows the first without a gap
        repeat (2) begin
            driveIdle();
            valid = 1'b1;
            unit = UnitMul;
            intRegWriteEnable = 1'b1;
            rd = 5'd7;
            rs1Value = $random(seed);
            rs2Value = $random(seed);
            product = word_t'(rs1Value * rs2Value);
            stallCycles = 0;
            #5;
            while (exStallReq) begin
                stallCycles++;
                if (stallCycles > 1 && outValid !== 1'b0) reportMismatch("outValid", 0, outValid);
                if (bypassWriteEnable !== 1'b0) begin
                    reportMismatch("bypassWriteEnable", 0, bypassWriteEnable);
                end
                @(negedge clk);
                #5;
            end
            if (stallCycles != MulCycles) begin
                reportMismatch("exStallReq cycles", MulCycles, stallCycles);
            end
            if (bypassWriteValue !== product) reportMismatch("bypassWriteValue", product, bypassWriteValue);
            @(negedge clk);
            if (outValid !== 1'b1) reportMismatch("outValid", 1, outValid);
            if (outDstValue !== product) reportMismatch("outDstValue", product, outDstValue);
        end
        driveIdle();
        reportTest("multiply", startErrors);
    endtask

    task automatic checkTrap(logic expTrap, excCode_t expCode, word_t expValue, logic expReturn,
                             logic expCsrWrite, word_t expCsrValue);
        logic expFlush;
        expFlush = expTrap || expReturn || csrWriteEnableReq;
        #5;
        if (flushReq !== expFlush) reportMismatch("flushReq", expFlush, flushReq);
        if (csrWriteEnable !== expCsrWrite) reportMismatch("csrWriteEnable", expCsrWrite, csrWriteEnable);
        if (expCsrWrite && csrWriteValue !== expCsrValue) begin
            reportMismatch("csrWriteValue", expCsrValue, csrWriteValue);
        end
        @(negedge clk);
        if (outTrapValid !== expTrap) reportMismatch("outTrapValid", expTrap, outTrapValid);
        if (outTrapReturn !== expReturn) reportMismatch("outTrapReturn", expReturn, outTrapReturn);
        if (expTrap && outTrapCode !== expCode) reportMismatch("outTrapCode", expCode, outTrapCode);
        if (expTrap && outTrapValue !== expValue) reportMismatch("outTrapValue", expValue, outTrapValue);
    endtask

    task automatic testTraps();
        int startErrors;
        privilege_t privs[3];
        startErrors = errorCount;
        privs = '{PrivUser, PrivSupervisor, PrivMachine};
        for (int i = 0; i < 3; i++) begin
            driveIdle();
            valid = 1'b1;
            insn = $random(seed);
            trapOp = TrapEcall;
            privilege = privs[i];
            checkTrap(1'b1, excCode_t'(8 + int'(privs[i])), 0, 1'b0, 1'b0, 0);
        end
        driveIdle();
        valid = 1'b1;
        insn = $random(seed);
        trapOp = TrapEbreak;
        checkTrap(1'b1, ExcBreakpoint, 0, 1'b0, 1'b0, 0);
        // satp write from supervisor with TVM set
        driveIdle();
        valid = 1'b1;
        insn = $random(seed);
        privilege = PrivSupervisor;
        statusTvm = 1'b1;
        csrWriteEnableReq = 1'b1;
        csrAddr = CsrAddrSatp;
        checkTrap(1'b1, ExcIllegalInsn, insn, 1'b0, 1'b0, 0);
        driveIdle();
        valid = 1'b1;
        insn = $random(seed);
        privilege = PrivSupervisor;
        isTrapReturn = 1'b1;
        trapReturnPriv = PrivSupervisor;
        statusTsr = 1'b1;
        checkTrap(1'b1, ExcIllegalInsn, insn, 1'b0, 1'b0, 0);
        driveIdle();
        valid = 1'b1;
        insn = $random(seed);
        privilege = PrivUser;
        isWfi = 1'b1;
        statusTw = 1'b1;
        checkTrap(1'b1, ExcIllegalInsn, insn, 1'b0, 1'b0, 0);
        privilege = PrivMachine;
        checkTrap(1'b0, 0, 0, 1'b0, 1'b0, 0);
        // plain mret
        driveIdle();
        valid = 1'b1;
        isTrapReturn = 1'b1;
        trapReturnPriv = PrivMachine;
        checkTrap(1'b0, 0, 0, 1'b1, 1'b0, 0);
        driveIdle();
        valid = 1'b1;
        privilege = PrivMachine;
        statusTvm = 1'b1;
        csrWriteEnableReq = 1'b1;
        csrAddr = CsrAddrSatp;
        aluCommand = AluOr;
        aluSrc1Sel = Src1Csr;
        aluSrc2Sel = Src2Reg;
        csrReadValue = $random(seed);
        rs2Value = $random(seed);
        checkTrap(1'b0, 0, 0, 1'b0, 1'b1, aluRef(AluOr, csrReadValue, rs2Value));
        driveIdle();
        reportTest("trap", startErrors);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        seed = 32'hedf136b2;
        errorCount = 0;
        testCount = 0;
        driveIdle();
        rstN = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        testReset();
        testAlu();
        testBranch();
        testMultiply();
        testTraps();
        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: build.f
execPkg.sv
aluUnit.sv
branchUnit.sv
mulUnit.sv
trapDetect.sv
executeStage.sv
executeStageTb.sv

// File: Bender.yml
package:
  name: execute_stage

sources:
  - execPkg.sv
  - aluUnit.sv
  - branchUnit.sv
  - mulUnit.sv
  - trapDetect.sv
  - executeStage.sv
  - target: simulation
    files:
      - executeStageTb.sv
